//--- compile.f
verilog/execute_pkg.sv
verilog/fu_branch.sv
verilog/fu_alu.sv
verilog/fu_scalar_ls.sv
verilog/fu_matrix_ls.sv
verilog/fu_gemm.sv
verilog/execute.sv
sim/clock_gen.sv
sim/execute_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module execute_tb -o execute_sim
./obj_dir/execute_sim

//--- sim/execute_tb.sv
// Execute stage testbench: stimulus, memory models, reference functions, compare tasks
module execute_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cycles = 4000;

    logic CLK, reset, ihit, dhit_in, mhit, gemm_flush, gemm_freeze, sls_dhit;
    logic [31:0] dmem_in, dmemload, fetch_p;
    execute_pkg::branch_req_t bfu_req;
    execute_pkg::branch_res_t bfu_res, exp_br;
    execute_pkg::alu_req_t    salu_req;
    execute_pkg::alu_res_t    salu_res;
    execute_pkg::sls_req_t    sls_req;
    execute_pkg::dmem_req_t   dmem_req;
    execute_pkg::mls_req_t    mls_req;
    execute_pkg::mls_res_t    mls_res;
    execute_pkg::gemm_regs_t  gemm_regs, exp_gemm;
    logic [31:0] dmem [0:15];
    logic [31:0] shadow [0:15];
    int cycles = 0;

    clock_gen i_clk (.CLK(CLK), .reset(reset));

    execute i_dut (.*);

    function automatic execute_pkg::alu_res_t ref_alu(execute_pkg::alu_req_t r);
        execute_pkg::alu_res_t e;
        longint s;
        e = '0;
        s = 0;
        case (r.aluop)
            execute_pkg::alu_add: s = longint'($signed(r.port_a)) + longint'($signed(r.port_b));
            execute_pkg::alu_sub: s = longint'($signed(r.port_a)) - longint'($signed(r.port_b));
            execute_pkg::alu_and: e.port_output = r.port_a & r.port_b;
            execute_pkg::alu_or:  e.port_output = r.port_a | r.port_b;
            execute_pkg::alu_xor: e.port_output = r.port_a ^ r.port_b;
            execute_pkg::alu_sll: e.port_output = r.port_a << r.port_b[4:0];
            execute_pkg::alu_srl: e.port_output = r.port_a >> r.port_b[4:0];
            execute_pkg::alu_sra: e.port_output = $signed(r.port_a) >>> r.port_b[4:0];
            execute_pkg::alu_slt: e.port_output = 32'($signed(r.port_a) < $signed(r.port_b));
            default:              e.port_output = 32'(r.port_a < r.port_b);
        endcase
        if (r.aluop == execute_pkg::alu_add || r.aluop == execute_pkg::alu_sub) begin
            e.port_output = s[31:0];
            // Result outside the signed 32-bit range
            e.overflow = (s > 64'sh7fffffff) || (s < -64'sh80000000);
        end
        e.negative = e.port_output[31];
        e.zero     = (e.port_output == 32'd0);
        return e;
    endfunction

    function automatic execute_pkg::branch_res_t ref_branch(execute_pkg::branch_req_t r);
        execute_pkg::branch_res_t e;
        logic t;
        case (r.branch_type)
            execute_pkg::br_beq:  t = r.reg_a == r.reg_b;
            execute_pkg::br_bne:  t = r.reg_a != r.reg_b;
            execute_pkg::br_blt:  t = $signed(r.reg_a) < $signed(r.reg_b);
            execute_pkg::br_bge:  t = !($signed(r.reg_a) < $signed(r.reg_b));
            execute_pkg::br_bltu: t = r.reg_a < r.reg_b;
            default:              t = !(r.reg_a < r.reg_b);
        endcase
        e.branch_outcome = t;
        e.branch_target  = r.current_pc + r.imm;
        e.correct_pc     = t ? e.branch_target : r.current_pc + 32'd4;
        e.updated_pc     = e.correct_pc;
        e.misprediction  = t ^ r.predicted_outcome;
        e.update_pc      = e.misprediction;
        return e;
    endfunction

    function automatic execute_pkg::gemm_regs_t ref_gemm(logic [31:0] w);
        return '{rs1: w[19:15], rs2: w[24:20], rs3: w[31:27], rd: w[11:7]};
    endfunction

    function automatic execute_pkg::mls_res_t ref_mls(execute_pkg::mls_req_t r);
        return '{done: 1'b1, ls_out: r.ls_in, rd_out: r.rd_in,
                 address: r.rs_in + r.imm_in, stride_out: r.stride_in};
    endfunction

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_alu(string name, execute_pkg::alu_res_t got, execute_pkg::alu_res_t exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_branch(string name, execute_pkg::branch_res_t got,
                                execute_pkg::branch_res_t exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_mls(string name, execute_pkg::mls_res_t got, execute_pkg::mls_res_t exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_gemm(string name, execute_pkg::gemm_regs_t got,
                              execute_pkg::gemm_regs_t exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    // Expected registered results, tracked from the inputs seen at each edge
    always @(posedge CLK) begin
        if (reset) begin
            exp_br   <= '0;
            exp_gemm <= '0;
        end else begin
            exp_br.update_pc <= 1'b0;
            if (bfu_req.branch && ihit) exp_br <= ref_branch(bfu_req);
            if (gemm_flush) exp_gemm <= '0;
            else if (!gemm_freeze && fetch_p[6:0] == execute_pkg::gemm_opcode)
                exp_gemm <= ref_gemm(fetch_p);
        end
    end

    // Comparing process
    always @(negedge CLK) begin
        if (!reset) begin
            check_alu("salu_res", salu_res, ref_alu(salu_req));
            check_branch("bfu_res", bfu_res, exp_br);
            check_gemm("gemm_regs", gemm_regs, exp_gemm);
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Simulation failed");
            $fatal(1, "Run did not finish within the cycle limit");
        end
    end

    task automatic sls_access(execute_pkg::mem_type_t t, int k, logic [31:0] data);
        logic [31:0] base;
        int hits;
        base = $urandom;
        hits = 0;
        @(posedge CLK);
        sls_req <= '{mem_type: t, rs1: base, rs2: data, imm: 32'(k * 4) - base};
        @(posedge CLK);
        sls_req.mem_type <= execute_pkg::mem_none;
        repeat ($urandom % 6) @(posedge CLK);
        @(negedge CLK);
        check_word("dmemaddr", dmem_req.dmemaddr, 32'(k * 4));
        check_word("dmemREN", 32'(dmem_req.dmemREN), 32'(t == execute_pkg::mem_load));
        check_word("dmemWEN", 32'(dmem_req.dmemWEN), 32'(t == execute_pkg::mem_store));
        // Memory answers on the next edge
        @(posedge CLK);
        dhit_in <= 1'b1;
        dmem_in <= dmem[k];
        if (dmem_req.dmemWEN) dmem[k] = dmem_req.dmemstore;
        @(posedge CLK);
        dhit_in <= 1'b0;
        repeat (3) begin
            @(negedge CLK);
            if (sls_dhit) begin
                hits++;
                if (t == execute_pkg::mem_load) check_word("dmemload", dmemload, shadow[k]);
            end
        end
        if (hits != 1) report_fail("Scalar access did not give exactly one sls_dhit");
        if (t == execute_pkg::mem_store) shadow[k] = data;
    endtask

    task automatic mls_access();
        execute_pkg::mls_req_t r;
        int hits;
        hits = 0;
        r = '{enable: 1'b1, ls_in: 1'($urandom), rd_in: 5'($urandom), rs_in: $urandom,
              stride_in: $urandom, imm_in: $urandom};
        @(posedge CLK);
        mls_req <= r;
        @(posedge CLK);
        mls_req.enable <= 1'b0;
        repeat ($urandom % 6) @(posedge CLK);
        mhit <= 1'b1;
        @(posedge CLK);
        mhit <= 1'b0;
        repeat (3) begin
            @(negedge CLK);
            if (mls_res.done) begin
                hits++;
                check_mls("mls_res", mls_res, ref_mls(r));
            end
        end
        if (hits != 1) report_fail("Matrix access did not give exactly one done pulse");
    endtask

    initial begin
        void'($urandom(32'hda06_ca3c));
        {ihit, dhit_in, mhit, gemm_flush, gemm_freeze} = '0;
        {dmem_in, fetch_p} = '0;
        {bfu_req, salu_req, sls_req, mls_req} = '0;
        for (int i = 0; i < 16; i++) begin
            dmem[i]   = 32'hc0de_0000 ^ (i * 4);
            shadow[i] = dmem[i];
        end
        repeat (8) @(negedge CLK);
        if ({bfu_res, mls_res, gemm_regs, dmem_req, dmemload, sls_dhit} !== '0)
            report_fail("Registered outputs not zero during reset");
        while (reset) @(posedge CLK);
        for (int i = 0; i < 200; i++) begin
            salu_req <= '{aluop: execute_pkg::alu_op_t'(i % 10),
                          port_a: (i % 3 == 0) ? 32'h7fff_ffff : $urandom,
                          port_b: (i % 4 == 0) ? 32'h8000_0001 : $urandom};
            @(posedge CLK);
        end
        for (int i = 0; i < 200; i++) begin
            bfu_req <= '{branch: 1'($urandom), branch_type: execute_pkg::branch_type_t'(i % 6),
                         reg_a: $urandom % 8, reg_b: (i % 5 == 0) ? 32'hffff_fff0 : $urandom % 8,
                         current_pc: $urandom, imm: $urandom, predicted_outcome: 1'($urandom)};
            ihit <= ($urandom % 4) != 0;
            @(posedge CLK);
        end
        bfu_req.branch <= 1'b0;
        for (int k = 0; k < 16; k++) sls_access(execute_pkg::mem_store, k, $urandom);
        for (int k = 0; k < 16; k++) sls_access(execute_pkg::mem_load, k, 32'd0);
        for (int i = 0; i < 40; i++) mls_access();
        @(posedge CLK);
        for (int i = 0; i < 200; i++) begin
            fetch_p     <= ($urandom % 2) ? {$urandom} : {25'($urandom), execute_pkg::gemm_opcode};
            gemm_freeze <= ($urandom % 4) == 0;
            gemm_flush  <= ($urandom % 8) == 0;
            @(posedge CLK);
        end
        {gemm_flush, gemm_freeze} <= 2'b00;
        repeat (2) @(posedge CLK);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- sim/clock_gen.sv
// Testbench clock (20 ns period) and synchronous reset generator
module clock_gen (
    output logic CLK,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK   = 1'b0;
        reset = 1'b1;
        repeat (16) @(posedge CLK);
        reset <= 1'b0;
    end

    always #10 CLK = ~CLK;

endmodule

//--- verilog/execute.sv
// Execute stage top: branch, scalar ALU, scalar and matrix load/store, GEMM units
module execute (
    input  logic                            CLK,
    input  logic                            reset,
    input  logic                            ihit,
    input  execute_pkg::branch_req_t        bfu_req,
    output execute_pkg::branch_res_t        bfu_res,
    input  execute_pkg::alu_req_t           salu_req,
    output execute_pkg::alu_res_t           salu_res,
    input  execute_pkg::sls_req_t           sls_req,
    input  logic [execute_pkg::word_w-1:0]  dmem_in,
    input  logic                            dhit_in,
    output execute_pkg::dmem_req_t          dmem_req,
    output logic [execute_pkg::word_w-1:0]  dmemload,
    output logic                            sls_dhit,
    input  execute_pkg::mls_req_t           mls_req,
    input  logic                            mhit,
    output execute_pkg::mls_res_t           mls_res,
    input  logic [execute_pkg::word_w-1:0]  fetch_p,
    input  logic                            gemm_flush,
    input  logic                            gemm_freeze,
    output execute_pkg::gemm_regs_t         gemm_regs
);

    fu_branch BFU (.CLK(CLK), .reset(reset), .ihit(ihit), .req(bfu_req), .res(bfu_res));

    fu_alu SALU (.req(salu_req), .res(salu_res));

    // Scalar memory side
    fu_scalar_ls SLS (
        .CLK(CLK), .reset(reset), .req(sls_req), .dmem_in(dmem_in), .dhit_in(dhit_in),
        .dmem_req(dmem_req), .dmemload(dmemload), .dhit(sls_dhit)
    );

    // Matrix memory side
    fu_matrix_ls MLS (.CLK(CLK), .reset(reset), .req(mls_req), .mhit(mhit), .res(mls_res));

    fu_gemm GEMM (
        .CLK(CLK), .reset(reset), .fetch_p(fetch_p), .flush(gemm_flush),
        .freeze(gemm_freeze), .regs(gemm_regs)
    );

endmodule

//--- verilog/fu_gemm.sv
// GEMM unit: opcode decode and register field latch with flush and freeze
module fu_gemm (
    input  logic                            CLK,
    input  logic                            reset,
    input  logic [execute_pkg::word_w-1:0]  fetch_p,
    input  logic                            flush,
    input  logic                            freeze,
    output execute_pkg::gemm_regs_t         regs
);

    logic                    is_gemm;
    execute_pkg::gemm_regs_t fields;

    assign is_gemm = (fetch_p[6:0] == execute_pkg::gemm_opcode);

    // R4 layout
    always_comb begin
        fields.rd  = fetch_p[11:7];
        fields.rs1 = fetch_p[19:15];
        fields.rs2 = fetch_p[24:20];
        fields.rs3 = fetch_p[31:27];
    end

    // Flush wins over freeze
    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            regs <= '0;
        end else if (!freeze && is_gemm) begin
            regs <= fields;
        end
    end

endmodule

//--- verilog/fu_matrix_ls.sv
// Matrix load/store unit: tile address, descriptor latch and matrix-memory wait
module fu_matrix_ls (
    input  logic                  CLK,
    input  logic                  reset,
    input  execute_pkg::mls_req_t req,
    input  logic                  mhit,
    output execute_pkg::mls_res_t res
);

    logic busy;
    logic start;

    // Requests arriving mid-access are dropped
    assign start = req.enable && !busy;

    always_ff @(posedge CLK) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (busy && mhit) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            res <= '0;
        end else begin
            res.done <= busy && mhit;
            // Descriptor is held until the next request
            if (start) begin
                res.address    <= req.rs_in + req.imm_in;
                res.stride_out <= req.stride_in;
                res.rd_out     <= req.rd_in;
                res.ls_out     <= req.ls_in;
            end
        end
    end

    assert property (
        @(posedge CLK) disable iff (reset)
        res.done |=> !res.done
    ) else $error("mls done held longer than one cycle");

endmodule

//--- verilog/fu_scalar_ls.sv
// Scalar load/store unit: address generation, data-memory request and hit wait
module fu_scalar_ls (
    input  logic                            CLK,
    input  logic                            reset,
    input  execute_pkg::sls_req_t           req,
    input  logic [execute_pkg::word_w-1:0]  dmem_in,
    input  logic                            dhit_in,
    output execute_pkg::dmem_req_t          dmem_req,
    output logic [execute_pkg::word_w-1:0]  dmemload,
    output logic                            dhit
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    state_t state;
    logic   start;

    assign start = (state == st_idle) && (req.mem_type != execute_pkg::mem_none);

    always_ff @(posedge CLK) begin
        if (reset) begin
            state    <= st_idle;
            dmem_req <= '0;
            dmemload <= '0;
            dhit     <= 1'b0;
        end else begin
            dhit <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        dmem_req.dmemaddr  <= req.rs1 + req.imm;
                        dmem_req.dmemstore <= req.rs2;
                        dmem_req.dmemREN   <= (req.mem_type == execute_pkg::mem_load);
                        dmem_req.dmemWEN   <= (req.mem_type == execute_pkg::mem_store);
                        state              <= st_busy;
                    end
                end
                st_busy: begin
                    // Enables stay up until memory answers
                    if (dhit_in) begin
                        if (dmem_req.dmemREN) begin
                            dmemload <= dmem_in;
                        end
                        dmem_req.dmemREN <= 1'b0;
                        dmem_req.dmemWEN <= 1'b0;
                        dhit             <= 1'b1;
                        state            <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assert property (
        @(posedge CLK) disable iff (reset)
        !(dmem_req.dmemREN && dmem_req.dmemWEN)
    ) else $error("dmemREN and dmemWEN high together");

endmodule

//--- verilog/fu_alu.sv
// Scalar ALU with negative, zero and signed overflow flags
module fu_alu (
    input  execute_pkg::alu_req_t req,
    output execute_pkg::alu_res_t res
);

    localparam int w = execute_pkg::word_w;

    logic [w-1:0] a;
    logic [w-1:0] b;
    logic [w-1:0] result;
    logic [4:0]   shamt;

    assign a     = req.port_a;
    assign b     = req.port_b;
    assign shamt = b[4:0];

    always_comb begin
        case (req.aluop)
            execute_pkg::alu_add:  result = a + b;
            execute_pkg::alu_sub:  result = a - b;
            execute_pkg::alu_and:  result = a & b;
            execute_pkg::alu_or:   result = a | b;
            execute_pkg::alu_xor:  result = a ^ b;
            execute_pkg::alu_sll:  result = a << shamt;
            execute_pkg::alu_srl:  result = a >> shamt;
            execute_pkg::alu_sra:  result = $signed(a) >>> shamt;
            execute_pkg::alu_slt:  result = {{(w-1){1'b0}}, $signed(a) < $signed(b)};
            execute_pkg::alu_sltu: result = {{(w-1){1'b0}}, a < b};
            default:               result = '0;
        endcase
    end

    always_comb begin
        res.port_output = result;
        res.negative    = result[w-1];
        res.zero        = (result == '0);
        // Signed overflow, add and sub only
        case (req.aluop)
            execute_pkg::alu_add:
                res.overflow = (a[w-1] == b[w-1]) && (result[w-1] != a[w-1]);
            execute_pkg::alu_sub:
                res.overflow = (a[w-1] != b[w-1]) && (result[w-1] != a[w-1]);
            default:
                res.overflow = 1'b0;
        endcase
    end

    // Flag seen at the port agrees with the word seen at the port
    always_comb begin
        assert (res.zero == (res.port_output == '0))
            else $error("zero flag disagrees with ALU result");
    end

endmodule

//--- verilog/fu_branch.sv
// Branch unit: condition evaluation, target calculation and misprediction report
module fu_branch (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     ihit,
    input  execute_pkg::branch_req_t req,
    output execute_pkg::branch_res_t res
);

    logic                           taken;
    logic                           qualified;
    logic [execute_pkg::word_w-1:0] target;
    logic [execute_pkg::word_w-1:0] fall_through;

    // Comparison is fixed by the branch type
    always_comb begin
        case (req.branch_type)
            execute_pkg::br_beq:  taken = (req.reg_a == req.reg_b);
            execute_pkg::br_bne:  taken = (req.reg_a != req.reg_b);
            execute_pkg::br_blt:  taken = ($signed(req.reg_a) < $signed(req.reg_b));
            execute_pkg::br_bge:  taken = ($signed(req.reg_a) >= $signed(req.reg_b));
            execute_pkg::br_bltu: taken = (req.reg_a < req.reg_b);
            execute_pkg::br_bgeu: taken = (req.reg_a >= req.reg_b);
            default:              taken = 1'b0;
        endcase
    end

    assign target       = req.current_pc + req.imm;
    assign fall_through = req.current_pc + execute_pkg::word_w'(4);

    // Only a fetched branch instruction is resolved
    assign qualified = req.branch & ihit;

    always_ff @(posedge CLK) begin
        if (reset) begin
            res <= '0;
        end else begin
            // Redirect request lasts one cycle
            res.update_pc <= 1'b0;
            if (qualified) begin
                res.branch_outcome <= taken;
                res.branch_target  <= target;
                res.correct_pc     <= taken ? target : fall_through;
                res.updated_pc     <= taken ? target : fall_through;
                res.misprediction  <= (taken != req.predicted_outcome);
                res.update_pc      <= (taken != req.predicted_outcome);
            end
        end
    end

    // A redirect follows a resolved branch that was guessed wrong
    assert property (
        @(posedge CLK) disable iff (reset)
        res.update_pc |-> (res.misprediction && $past(qualified))
    ) else $error("update_pc without a resolved misprediction");

endmodule

//--- verilog/execute_pkg.sv
// Shared widths, opcode enums, GEMM opcode and request/result structs for the execute stage
package execute_pkg;

    // Datapath widths
    localparam int word_w    = 32;
    localparam int reg_idx_w = 5;

    // Major opcode of a GEMM instruction (custom-3 space)
    localparam logic [6:0] gemm_opcode = 7'b1111011;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_t;

    typedef enum logic [2:0] {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd2,
        br_bge  = 3'd3,
        br_bltu = 3'd4,
        br_bgeu = 3'd5
    } branch_type_t;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_type_t;

    typedef struct packed {
        logic                branch;
        branch_type_t        branch_type;
        logic [word_w-1:0]   reg_a;
        logic [word_w-1:0]   reg_b;
        logic [word_w-1:0]   current_pc;
        logic [word_w-1:0]   imm;
        logic                predicted_outcome;
    } branch_req_t;

    typedef struct packed {
        logic                branch_outcome;
        logic [word_w-1:0]   branch_target;
        logic [word_w-1:0]   correct_pc;
        logic [word_w-1:0]   updated_pc;
        logic                misprediction;
        logic                update_pc;
    } branch_res_t;

    typedef struct packed {
        alu_op_t             aluop;
        logic [word_w-1:0]   port_a;
        logic [word_w-1:0]   port_b;
    } alu_req_t;

    typedef struct packed {
        logic [word_w-1:0]   port_output;
        logic                negative;
        logic                zero;
        logic                overflow;
    } alu_res_t;

    // rs2 carries the store data
    typedef struct packed {
        mem_type_t           mem_type;
        logic [word_w-1:0]   rs1;
        logic [word_w-1:0]   rs2;
        logic [word_w-1:0]   imm;
    } sls_req_t;

    typedef struct packed {
        logic [word_w-1:0]   dmemaddr;
        logic                dmemREN;
        logic                dmemWEN;
        logic [word_w-1:0]   dmemstore;
    } dmem_req_t;

    // ls_in high means store
    typedef struct packed {
        logic                enable;
        logic                ls_in;
        logic [reg_idx_w-1:0] rd_in;
        logic [word_w-1:0]   rs_in;
        logic [word_w-1:0]   stride_in;
        logic [word_w-1:0]   imm_in;
    } mls_req_t;

    typedef struct packed {
        logic                done;
        logic                ls_out;
        logic [reg_idx_w-1:0] rd_out;
        logic [word_w-1:0]   address;
        logic [word_w-1:0]   stride_out;
    } mls_res_t;

    typedef struct packed {
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs3;
        logic [reg_idx_w-1:0] rd;
    } gemm_regs_t;

endpackage
